/* logic/idu_params.svh */
`ifndef IDU_PARAMS_SVH
`define IDU_PARAMS_SVH

// --------------------
// datapath widths
// --------------------
`define IDU_XLEN        32      // data and pc width
`define IDU_REG_AW      5       // register index width
`define IDU_NUM_REGS    32      // x0..x31, x0 hardwired

// sequential pc advance when fetch is idle
`define IDU_PC_STEP     32'd4

// --------------------
// rv32 major opcodes
// --------------------
`define IDU_OP_LOAD     7'b0000011  // lb/lh/lw/lbu/lhu
`define IDU_OP_STORE    7'b0100011  // sb/sh/sw
`define IDU_OP_BRANCH   7'b1100011  // beq..bgeu
`define IDU_OP_ALU_IMM  7'b0010011  // addi, andi, shifts
`define IDU_OP_ALU_REG  7'b0110011  // add, sub, and ...
`define IDU_OP_LUI      7'b0110111  // upper immediate

`endif

/* logic/idu_pkg.sv */
package idu_pkg;

    // R-type view, register indices
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I-type view, 12-bit immediate
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_INVALID
    } instr_class_e;

    typedef struct packed {
        instr_u      instr;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        logic [4:0]  idx;
        logic        squash;    // result discarded
        logic [31:0] value;
    } wb_t;

    typedef struct packed {
        instr_class_e cls;
        logic [31:0]  instr;
        logic [31:0]  pc;
        logic [4:0]   rd;
        logic [4:0]   ra;
        logic [4:0]   rb;
        logic [31:0]  imm;      // sign-extended I immediate
    } opcode_t;

endpackage

/* logic/idu_fetch_decode.sv */
`timescale 1ns/10ps
`include "idu_params.svh"

module idu_fetch_decode (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 fetch_valid_i,
    input  idu_pkg::fetch_t      fetch_i,
    input  logic                 branch_request_i,
    input  logic [`IDU_XLEN-1:0] branch_pc_i,
    input  logic                 hold_i,
    output logic                 valid_o,
    output idu_pkg::opcode_t     opcode_o
);

    import idu_pkg::*;

    instr_u       word;
    instr_class_e cls;
    opcode_t      dec;
    opcode_t      op_q;
    logic         valid_q;

    assign word = fetch_i.instr;

    // --------------------
    // class decode
    // --------------------
    always_comb
    begin
        case (word.r_fields.opcode)
            `IDU_OP_LOAD:    cls = CLS_LOAD;
            `IDU_OP_STORE:   cls = CLS_STORE;
            `IDU_OP_BRANCH:  cls = CLS_BRANCH;
            `IDU_OP_ALU_IMM,
            `IDU_OP_ALU_REG,
            `IDU_OP_LUI:     cls = CLS_ALU;
            default:         cls = CLS_INVALID;
        endcase
    end

    // fields of the incoming word, registered below
    always_comb
    begin
        dec.cls   = cls;
        dec.instr = word;
        dec.rd    = word.r_fields.rd;
        dec.ra    = word.r_fields.rs1;
        dec.rb    = word.r_fields.rs2;
        dec.imm   = {{(`IDU_XLEN-12){word.i_fields.imm12[11]}}, word.i_fields.imm12};

        if (fetch_valid_i)
            dec.pc = fetch_i.pc;
        else if (valid_q)
            dec.pc = op_q.pc + `IDU_PC_STEP;    // held instr consumed, move on
        else
            dec.pc = op_q.pc;
    end

    // --------------------
    // instruction register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            op_q    <= '0;
        end
        else if (branch_request_i)
        begin
            valid_q <= 1'b0;            // drop held instr
            op_q    <= '0;
            op_q.pc <= branch_pc_i;     // redirect target
        end
        else if (!hold_i)
        begin
            valid_q <= fetch_valid_i;
            op_q    <= dec;
        end
    end

    assign valid_o  = valid_q;
    assign opcode_o = op_q;

endmodule

/* logic/idu_regfile.sv */
`timescale 1ns/10ps
`include "idu_params.svh"

module idu_regfile (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  idu_pkg::wb_t           wb_exec_i,
    input  idu_pkg::wb_t           wb_mem_i,
    input  logic [`IDU_REG_AW-1:0] ra_i,
    input  logic [`IDU_REG_AW-1:0] rb_i,
    output logic [`IDU_XLEN-1:0]   ra_value_o,
    output logic [`IDU_XLEN-1:0]   rb_value_o
);

    logic [`IDU_XLEN-1:0] regs_q [1:`IDU_NUM_REGS-1];   // no storage for x0
    logic                 exec_we;
    logic                 mem_we;

    assign exec_we = !wb_exec_i.squash && (wb_exec_i.idx != '0);
    assign mem_we  = !wb_mem_i.squash && (wb_mem_i.idx != '0);

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < `IDU_NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else
        begin
            if (exec_we)
                regs_q[wb_exec_i.idx] <= wb_exec_i.value;
            if (mem_we)
                regs_q[wb_mem_i.idx] <= wb_mem_i.value;     // mem wins on same idx
        end
    end

    assign ra_value_o = (ra_i == '0) ? '0 : regs_q[ra_i];
    assign rb_value_o = (rb_i == '0) ? '0 : regs_q[rb_i];

endmodule

/* logic/idu_issue.sv */
`timescale 1ns/10ps
`include "idu_params.svh"

module idu_issue (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  idu_pkg::opcode_t     opcode_i,
    input  logic [`IDU_XLEN-1:0] ra_value_i,
    input  logic [`IDU_XLEN-1:0] rb_value_i,
    input  idu_pkg::wb_t         wb_exec_i,
    input  idu_pkg::wb_t         wb_mem_i,
    input  logic                 exec_stall_i,
    input  logic                 lsu_stall_i,
    input  logic                 branch_request_i,
    output logic                 hold_o,
    output logic                 fetch_accept_o,
    output logic                 exec_opcode_valid_o,
    output logic                 lsu_opcode_valid_o,
    output logic [`IDU_XLEN-1:0] ra_operand_o,
    output logic [`IDU_XLEN-1:0] rb_operand_o
);

    import idu_pkg::*;

    logic [`IDU_NUM_REGS-1:0] sb_q;
    logic [`IDU_NUM_REGS-1:0] sb_cur;
    logic [`IDU_NUM_REGS-1:0] sb_next;
    logic                     stall_sb;
    logic                     stall_any;
    logic                     opcode_valid;
    logic                     load_issue;

    // exec result first, then mem, then the array
    function automatic logic [`IDU_XLEN-1:0] bypass(
        input logic [`IDU_REG_AW-1:0] idx,
        input logic [`IDU_XLEN-1:0]   rf_value,
        input wb_t                    exec_wb,
        input wb_t                    mem_wb
    );
        if (!exec_wb.squash && exec_wb.idx != '0 && exec_wb.idx == idx)
            return exec_wb.value;
        else if (!mem_wb.squash && mem_wb.idx != '0 && mem_wb.idx == idx)
            return mem_wb.value;
        else
            return rf_value;
    endfunction

    assign ra_operand_o = bypass(opcode_i.ra, ra_value_i, wb_exec_i, wb_mem_i);
    assign rb_operand_o = bypass(opcode_i.rb, rb_value_i, wb_exec_i, wb_mem_i);

    // --------------------
    // load scoreboard
    // --------------------
    always_comb
    begin
        sb_cur = sb_q;
        if (!wb_mem_i.squash)
            sb_cur[wb_mem_i.idx] = 1'b0;    // load data arriving now
        stall_sb = valid_i && (sb_cur[opcode_i.ra] ||
                               sb_cur[opcode_i.rb] ||
                               sb_cur[opcode_i.rd]);
    end

    assign load_issue = (opcode_i.cls == CLS_LOAD) && exec_opcode_valid_o && lsu_opcode_valid_o;

    always_comb
    begin
        sb_next = sb_cur;
        if (load_issue)
            sb_next[opcode_i.rd] = 1'b1;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            sb_q <= '0;
        else
            sb_q <= {sb_next[`IDU_NUM_REGS-1:1], 1'b0};   // x0 never pending
    end

    // --------------------
    // stall and issue
    // --------------------
    assign stall_any    = stall_sb || exec_stall_i || lsu_stall_i;
    assign opcode_valid = valid_i && !stall_sb;

    assign exec_opcode_valid_o = opcode_valid && !lsu_stall_i;
    assign lsu_opcode_valid_o  = opcode_valid && !exec_stall_i;

    assign hold_o         = stall_any && !branch_request_i;
    assign fetch_accept_o = branch_request_i || !stall_any;    // branch always taken

endmodule

/* logic/idu_top.sv */
`timescale 1ns/10ps

module idu_top (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             fetch_valid_i,
    input  idu_pkg::fetch_t  fetch_i,
    input  logic             branch_request_i,
    input  logic [31:0]      branch_pc_i,
    input  idu_pkg::wb_t     wb_exec_i,
    input  idu_pkg::wb_t     wb_mem_i,
    input  logic             exec_stall_i,
    input  logic             lsu_stall_i,
    output logic             fetch_accept_o,
    output logic             fetch_branch_o,
    output logic [31:0]      fetch_branch_pc_o,
    output logic             exec_opcode_valid_o,
    output logic             lsu_opcode_valid_o,
    output idu_pkg::opcode_t opcode_o,
    output logic [31:0]      ra_operand_o,
    output logic [31:0]      rb_operand_o
);

    logic        valid_w;
    logic        hold_w;
    logic [31:0] ra_value_w;
    logic [31:0] rb_value_w;

    // redirect goes straight back to fetch
    assign fetch_branch_o    = branch_request_i;
    assign fetch_branch_pc_o = branch_pc_i;

    idu_fetch_decode u_fetch_decode (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_i          (fetch_i),
        .branch_request_i (branch_request_i),
        .branch_pc_i      (branch_pc_i),
        .hold_i           (hold_w),
        .valid_o          (valid_w),
        .opcode_o         (opcode_o)
    );

    idu_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_exec_i  (wb_exec_i),
        .wb_mem_i   (wb_mem_i),
        .ra_i       (opcode_o.ra),
        .rb_i       (opcode_o.rb),
        .ra_value_o (ra_value_w),
        .rb_value_o (rb_value_w)
    );

    idu_issue u_issue (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .valid_i             (valid_w),
        .opcode_i            (opcode_o),
        .ra_value_i          (ra_value_w),
        .rb_value_i          (rb_value_w),
        .wb_exec_i           (wb_exec_i),
        .wb_mem_i            (wb_mem_i),
        .exec_stall_i        (exec_stall_i),
        .lsu_stall_i         (lsu_stall_i),
        .branch_request_i    (branch_request_i),
        .hold_o              (hold_w),
        .fetch_accept_o      (fetch_accept_o),
        .exec_opcode_valid_o (exec_opcode_valid_o),
        .lsu_opcode_valid_o  (lsu_opcode_valid_o),
        .ra_operand_o        (ra_operand_o),
        .rb_operand_o        (rb_operand_o)
    );

endmodule

/* sim/idu_checker.sv */
`timescale 1ns/10ps

module idu_checker (
    input logic clk_i,
    input logic rst_i,
    input logic lsu_stall_i,
    input logic fetch_branch_o,
    input logic exec_opcode_valid_o,
    input logic lsu_opcode_valid_o
);

    // --------------------
    // reset and redirect
    // --------------------
    a_quiet_in_reset : assert property (@(posedge clk_i)
        rst_i |-> (!exec_opcode_valid_o && !lsu_opcode_valid_o))
        else $error("issue valid high during reset");

    // held instruction is gone one edge after a redirect
    a_branch_flushes : assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_branch_o |=> (!exec_opcode_valid_o && !lsu_opcode_valid_o))
        else $error("issue valid high after a branch redirect");

    // lsu back-pressure must block exec issue
    a_exec_blocked : assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_stall_i |-> !exec_opcode_valid_o)
        else $error("exec valid high under lsu stall");

endmodule

bind idu_top idu_checker u_checker (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .lsu_stall_i         (lsu_stall_i),
    .fetch_branch_o      (fetch_branch_o),
    .exec_opcode_valid_o (exec_opcode_valid_o),
    .lsu_opcode_valid_o  (lsu_opcode_valid_o)
);

/* sim/idu_tb.sv */
`timescale 1ns/10ps

module idu_tb;

    import idu_pkg::*;

    localparam int ACCEPT_TIMEOUT = 16;     // cycles

    logic        clk_i;
    logic        rst_i;
    logic        fetch_valid_i;
    fetch_t      fetch_i;
    logic        branch_request_i;
    logic [31:0] branch_pc_i;
    wb_t         wb_exec_i;
    wb_t         wb_mem_i;
    logic        exec_stall_i;
    logic        lsu_stall_i;
    logic        fetch_accept_o;
    logic        fetch_branch_o;
    logic [31:0] fetch_branch_pc_o;
    logic        exec_opcode_valid_o;
    logic        lsu_opcode_valid_o;
    opcode_t     opcode_o;
    logic [31:0] ra_operand_o;
    logic [31:0] rb_operand_o;

    logic [31:0] f [26];        // one vector line
    logic [31:0] exp_instr;     // word held in the instruction register
    integer      fd;
    integer      n;
    integer      line_no;
    integer      errors;
    integer      checks;
    integer      tests;
    integer      test_errs;
    integer      cur_test;
    integer      cycles;
    string       line;

    idu_top u_dut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors    = errors + 1;
            test_errs = test_errs + 1;
            $display("error at %0t: test %0d line %0d %s is %h, expected %h",
                     $time, cur_test, line_no, name, got, exp);
        end
    endtask

    task automatic report_test();
        tests = tests + 1;
        $display("test %0d finished, %0d errors", cur_test, test_errs);
    endtask

    // hex fields of one text line into f, returns how many were found
    function automatic int split_fields(input string text);
        int         count;
        int         digit;
        bit         in_field;
        logic [7:0] c;
        count    = 0;
        in_field = 1'b0;
        for (int i = 0; i < text.len(); i++)
        begin
            c = text.getc(i);
            if (c >= "0" && c <= "9")
                digit = c - "0";
            else if (c >= "a" && c <= "f")
                digit = c - "a" + 10;
            else if (c >= "A" && c <= "F")
                digit = c - "A" + 10;
            else
                digit = -1;
            if (digit < 0)
                in_field = 1'b0;
            else
            begin
                if (!in_field)
                begin
                    count    = count + 1;
                    in_field = 1'b1;
                    if (count <= 26)
                        f[count-1] = '0;
                end
                if (count <= 26)
                    f[count-1] = {f[count-1][27:0], digit[3:0]};
            end
        end
        return count;
    endfunction

    // --------------------
    // drive one step
    // --------------------
    task automatic apply_step();
        fetch_valid_i    = f[2][0];
        fetch_i          = {f[3], f[4]};
        wb_exec_i        = {f[5][4:0], f[6][0], f[7]};
        wb_mem_i         = {f[8][4:0], f[9][0], f[10]};
        exec_stall_i     = f[11][0];
        lsu_stall_i      = f[12][0];
        branch_request_i = f[13][0];
        branch_pc_i      = f[14];
    endtask

    task automatic check_step();
        compare_field("fetch_accept_o", {31'd0, fetch_accept_o}, f[15]);
        compare_field("exec_opcode_valid_o", {31'd0, exec_opcode_valid_o}, f[16]);
        compare_field("lsu_opcode_valid_o", {31'd0, lsu_opcode_valid_o}, f[17]);
        compare_field("pc", opcode_o.pc, f[23]);
        compare_field("fetch_branch_o", {31'd0, fetch_branch_o}, f[13]);
        if (branch_request_i)
            compare_field("fetch_branch_pc_o", fetch_branch_pc_o, f[14]);
        if (f[1] != 0)
        begin
            compare_field("cls", {29'd0, opcode_o.cls}, f[18]);
            compare_field("instr", opcode_o.instr, exp_instr);
            compare_field("rd", {27'd0, opcode_o.rd}, f[19]);
            compare_field("ra", {27'd0, opcode_o.ra}, f[20]);
            compare_field("rb", {27'd0, opcode_o.rb}, f[21]);
            compare_field("imm", opcode_o.imm, f[22]);
            compare_field("ra_operand_o", ra_operand_o, f[24]);
            compare_field("rb_operand_o", rb_operand_o, f[25]);
        end
    endtask

    initial
    begin
        rst_i = 1'b1;
        for (int i = 0; i < 26; i++)
            f[i] = '0;
        f[6]  = 32'd1;      // idle writebacks are squashed
        f[9]  = 32'd1;
        apply_step();
        exp_instr = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        cur_test  = 0;
        line_no   = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        fd = $fopen("sim/idu_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the vector file sim/idu_vectors.txt");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                line_no = line_no + 1;
                if (n > 1 && line.getc(0) != "#")
                begin
                    n = split_fields(line);
                    if (n == 26)
                    begin
                        if (f[0] != cur_test)
                        begin
                            if (cur_test != 0)
                                report_test();
                            cur_test  = f[0];
                            test_errs = 0;
                        end
                        @(negedge clk_i);
                        apply_step();
                        #1;
                        if (f[1] == 2)
                        begin
                            cycles = 0;
                            while (!fetch_accept_o)
                            begin
                                if (cycles >= ACCEPT_TIMEOUT)
                                begin
                                    $display("timeout: fetch_accept_o stayed low in test %0d",
                                             cur_test);
                                    $display("TEST FAILED");
                                    $finish;
                                end
                                @(negedge clk_i);
                                #1;
                                cycles = cycles + 1;
                            end
                        end
                        check_step();
                        if (f[13][0])
                            exp_instr = '0;         // redirect clears the register
                        else if (f[15][0])
                            exp_instr = f[3];       // word taken at the coming edge
                    end
                    else if (n != 0)
                    begin
                        errors = errors + 1;
                        $display("vector line %0d has %0d fields instead of 26",
                                 line_no, n);
                    end
                end
            end
            $fclose(fd);
            if (cur_test != 0)
                report_test();
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0 && checks > 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* sim/idu_vectors.txt */
# test kind fv instr pc | exec idx sq val | mem idx sq val | es ls br br_pc
#   | acc ev lv cls rd ra rb imm pc ra_op rb_op   (kind 0 valids, 1 full, 2 wait)
1 0 1 FFF10093 100 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0
1 1 1 00822183 104 0 1 0 0 1 0 0 0 0 0 1 1 1 0 1 2 1F FFFFFFFF 100 0 0
1 1 1 0062A623 108 0 1 0 0 1 0 0 0 0 0 1 1 1 1 3 4 8 8 104 0 0
1 1 1 80208063 10C 0 1 0 3 0 0 0 0 0 0 1 1 1 2 C 5 6 6 108 0 0
1 1 1 7FF0007F 110 0 1 0 0 1 0 0 0 0 0 1 1 1 3 0 1 2 FFFFF802 10C 0 0
1 1 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1 1 4 0 0 1F 7FF 110 0 0
2 0 1 00028433 200 5 0 DEADBEEF 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 114 0 0
2 1 1 00600533 204 0 0 11111111 6 1 22222222 0 0 0 0 1 1 1 0 8 5 0 0 200 DEADBEEF 0
2 1 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1 1 0 A 0 6 6 204 0 0
3 0 1 000485B3 300 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 208 0 0
3 1 1 00048633 304 9 0 AAAA0001 9 0 BBBB0002 0 0 0 0 1 1 1 0 B 9 0 0 300 AAAA0001 0
3 1 0 0 0 0 1 0 9 0 CCCC0003 0 0 0 0 1 1 1 0 C 9 0 0 304 CCCC0003 0
4 0 1 00002383 400 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 308 0 0
4 1 1 000386B3 404 0 1 0 0 1 0 0 0 0 0 1 1 1 1 7 0 0 0 400 0 0
4 1 1 00500713 408 0 1 0 0 1 0 0 0 0 0 0 0 0 0 D 7 0 0 404 0 0
4 2 1 00500713 408 0 1 0 7 0 5A5A5A5A 0 0 0 0 1 1 1 0 D 7 0 0 404 5A5A5A5A 0
4 1 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1 1 0 E 0 5 5 408 0 DEADBEEF
5 0 1 00100093 500 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 40C 0 0
5 1 1 00200113 504 0 1 0 0 1 0 0 0 1 800 1 1 1 0 1 0 1 1 500 0 0
5 0 0 0 0 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 800 0 0
5 0 1 00100093 900 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 800 0 0
5 1 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1 1 0 1 0 1 1 900 0 0
5 0 0 0 0 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 904 0 0
6 0 1 005487B3 A00 0 1 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 904 0 0
6 1 1 00200113 A04 0 1 0 0 1 0 1 0 0 0 0 1 0 0 F 9 5 5 A00 CCCC0003 DEADBEEF
6 1 1 00200113 A04 0 1 0 0 1 0 0 1 0 0 0 0 1 0 F 9 5 5 A00 CCCC0003 DEADBEEF
6 2 1 00200113 A04 0 1 0 0 1 0 0 0 0 0 1 1 1 0 F 9 5 5 A00 CCCC0003 DEADBEEF
6 1 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1 1 0 2 0 2 2 A04 0 0

/* verilog.f */
+incdir+logic
logic/idu_pkg.sv
logic/idu_fetch_decode.sv
logic/idu_regfile.sv
logic/idu_issue.sv
logic/idu_top.sv
sim/idu_checker.sv
sim/idu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= idu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
